// File: src/hwlp_cfg_pkg.sv
// Address and counter widths, their types, instruction step size
`default_nettype none

package hwlp_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Byte address of one instruction
  localparam int unsigned ADDR_W = 32;

  // Iteration counter, same range as the host data word
  localparam int unsigned CNT_W = 32;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  // Fixed 32-bit instructions, no compressed forms
  localparam int unsigned INSTR_STEP = 4;

endpackage

`default_nettype wire

// File: src/hwlp_cmd_pkg.sv
// Host command opcodes and loop register write-enable positions
`default_nettype none

package hwlp_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // Command opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    // Loop start address for cmd_regid
    OP_START = 3'd0,
    // Loop end address, last body instruction
    OP_END   = 3'd1,
    // Iteration count, zero leaves the loop inactive
    OP_COUNT = 3'd2,
    // Last address of the run
    OP_STOP  = 3'd3,
    // Start streaming from the data address
    OP_RUN   = 3'd4
  } cmd_op_e;

  ////////////////////////////////////////////////////////////
  // Write-enable vector into the loop registers
  ////////////////////////////////////////////////////////////

  localparam int unsigned WE_W     = 3;
  localparam int unsigned WE_START = 0;
  localparam int unsigned WE_END   = 1;
  localparam int unsigned WE_CNT   = 2;

endpackage

`default_nettype wire

// File: src/hwlp_cmd_decode.sv
// Command stage: host command register, opcode decode, stop address register
`timescale 1ns/1ns
`default_nettype none

module hwlp_cmd_decode #(
  parameter int N_LOOPS = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Host command port
  input  logic                                   cmd_valid_i,
  input  hwlp_cmd_pkg::cmd_op_e                  cmd_op_i,
  input  logic [((N_LOOPS > 1) ? $clog2(N_LOOPS) : 1)-1:0] cmd_regid_i,
  input  hwlp_cfg_pkg::addr_t                    cmd_data_i,
  // Run state from the address generator
  input  logic                                   busy_i,
  // Loop register writes
  output logic [hwlp_cmd_pkg::WE_W-1:0]          hwlp_we_o,
  output logic [((N_LOOPS > 1) ? $clog2(N_LOOPS) : 1)-1:0] hwlp_regid_o,
  output hwlp_cfg_pkg::addr_t                    hwlp_start_data_o,
  output hwlp_cfg_pkg::addr_t                    hwlp_end_data_o,
  output hwlp_cfg_pkg::cnt_t                     hwlp_cnt_data_o,
  // Run control
  output logic                                   run_start_o,
  output hwlp_cfg_pkg::addr_t                    run_addr_o,
  output hwlp_cfg_pkg::addr_t                    stop_addr_o
);

  localparam int IDX_W = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1;

  logic                   cmd_vld_q;
  hwlp_cmd_pkg::cmd_op_e  cmd_op_q;
  logic [IDX_W-1:0]       cmd_regid_q;
  hwlp_cfg_pkg::addr_t    cmd_data_q;
  hwlp_cfg_pkg::addr_t    stop_addr_q;

  // Registered host command
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_vld_q   <= 1'b0;
      cmd_op_q    <= hwlp_cmd_pkg::OP_START;
      cmd_regid_q <= '0;
      cmd_data_q  <= '0;
    end
    else
    begin
      cmd_vld_q <= cmd_valid_i;
      if (cmd_valid_i)
      begin
        cmd_op_q    <= cmd_op_i;
        cmd_regid_q <= cmd_regid_i;
        cmd_data_q  <= cmd_data_i;
      end
    end
  end

  // Stop address lands one edge after the registered command
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stop_addr_q <= '0;
    end
    else if (cmd_vld_q && (cmd_op_q == hwlp_cmd_pkg::OP_STOP))
    begin
      stop_addr_q <= cmd_data_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  // One write-enable bit per command, or the run pulse
  always_comb
  begin
    hwlp_we_o = '0;
    hwlp_we_o[hwlp_cmd_pkg::WE_START] = cmd_vld_q && (cmd_op_q == hwlp_cmd_pkg::OP_START);
    hwlp_we_o[hwlp_cmd_pkg::WE_END]   = cmd_vld_q && (cmd_op_q == hwlp_cmd_pkg::OP_END);
    hwlp_we_o[hwlp_cmd_pkg::WE_CNT]   = cmd_vld_q && (cmd_op_q == hwlp_cmd_pkg::OP_COUNT);
  end

  assign run_start_o = cmd_vld_q && (cmd_op_q == hwlp_cmd_pkg::OP_RUN);

  // Same data word feeds every destination
  assign hwlp_regid_o      = cmd_regid_q;
  assign hwlp_start_data_o = cmd_data_q;
  assign hwlp_end_data_o   = cmd_data_q;
  assign hwlp_cnt_data_o   = hwlp_cfg_pkg::cnt_t'(cmd_data_q);
  assign run_addr_o        = cmd_data_q;
  assign stop_addr_o       = stop_addr_q;

  // Host protocol, busy comes from the address generator
  a_no_cmd_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n) cmd_valid_i |-> !busy_i
  );

endmodule

`default_nettype wire

// File: src/hwlp_regs.sv
// Loop register file: start, end and counter per loop with decrement path
`timescale 1ns/1ns
`default_nettype none

module hwlp_regs #(
  parameter int N_LOOPS = 2
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Writes from the command stage
  input  hwlp_cfg_pkg::addr_t                    hwlp_start_data_i,
  input  hwlp_cfg_pkg::addr_t                    hwlp_end_data_i,
  input  hwlp_cfg_pkg::cnt_t                     hwlp_cnt_data_i,
  input  logic [hwlp_cmd_pkg::WE_W-1:0]          hwlp_we_i,
  input  logic [((N_LOOPS > 1) ? $clog2(N_LOOPS) : 1)-1:0] hwlp_regid_i,
  // Issue strobe from the address generator
  input  logic                                   valid_i,
  // Decrement request from the loop controller
  input  logic [N_LOOPS-1:0]                     hwlp_dec_cnt_i,
  // Register contents to the loop controller
  output hwlp_cfg_pkg::addr_t [N_LOOPS-1:0]      hwlp_start_addr_o,
  output hwlp_cfg_pkg::addr_t [N_LOOPS-1:0]      hwlp_end_addr_o,
  output hwlp_cfg_pkg::cnt_t  [N_LOOPS-1:0]      hwlp_counter_o
);

  localparam int IDX_W = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1;

  hwlp_cfg_pkg::addr_t [N_LOOPS-1:0] start_q;
  hwlp_cfg_pkg::addr_t [N_LOOPS-1:0] end_q;
  hwlp_cfg_pkg::cnt_t  [N_LOOPS-1:0] counter_q;

  assign hwlp_start_addr_o = start_q;
  assign hwlp_end_addr_o   = end_q;
  assign hwlp_counter_o    = counter_q;

  ////////////////////////////////////////////////////////////
  // Per-loop register set
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < N_LOOPS; k++)
  begin : g_loop
    logic sel;
    logic dec;

    // This set addressed by the command
    assign sel = (hwlp_regid_i == IDX_W'(k));
    // Decrement only on an actual issue
    assign dec = hwlp_dec_cnt_i[k] && valid_i;

    // Start and end addresses
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        start_q[k] <= '0;
        end_q[k]   <= '0;
      end
      else
      begin
        if (sel && hwlp_we_i[hwlp_cmd_pkg::WE_START])
        begin
          start_q[k] <= hwlp_start_data_i;
        end
        if (sel && hwlp_we_i[hwlp_cmd_pkg::WE_END])
        begin
          end_q[k] <= hwlp_end_data_i;
        end
      end
    end

    // Counter, host write beats decrement
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        counter_q[k] <= '0;
      end
      else if (sel && hwlp_we_i[hwlp_cmd_pkg::WE_CNT])
      begin
        counter_q[k] <= hwlp_cnt_data_i;
      end
      else if (dec)
      begin
        counter_q[k] <= counter_q[k] - 1'b1;
      end
    end
  end

  // Controller must pick one loop per issued address
  a_single_dec : assert property (
    @(posedge clk) disable iff (!rst_n) valid_i |-> ($countones(hwlp_dec_cnt_i) <= 1)
  );

endmodule

`default_nettype wire

// File: src/hwlp_ctrl.sv
// Loop controller: end-address match, jump target and decrement select
`timescale 1ns/1ns
`default_nettype none

module hwlp_ctrl #(
  parameter int N_LOOPS = 2
) (
  // Current address from the address generator
  input  hwlp_cfg_pkg::addr_t                    pc_i,
  // Loop register contents
  input  hwlp_cfg_pkg::addr_t [N_LOOPS-1:0]      hwlp_start_addr_i,
  input  hwlp_cfg_pkg::addr_t [N_LOOPS-1:0]      hwlp_end_addr_i,
  input  hwlp_cfg_pkg::cnt_t  [N_LOOPS-1:0]      hwlp_counter_i,
  // Next-address advice
  output logic                                   jump_o,
  output hwlp_cfg_pkg::addr_t                    jump_addr_o,
  // One-hot or zero, strobed in the register file
  output logic [N_LOOPS-1:0]                     hwlp_dec_cnt_o
);

  // Per-loop match: active and ending here
  logic [N_LOOPS-1:0] hit;
  // Per-loop: more than one pass left
  logic [N_LOOPS-1:0] again;

  for (genvar k = 0; k < N_LOOPS; k++)
  begin : g_match
    assign hit[k]   = (hwlp_counter_i[k] != '0) && (hwlp_end_addr_i[k] == pc_i);
    assign again[k] = hwlp_counter_i[k] > hwlp_cfg_pkg::cnt_t'(1);
  end

  ////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////

  // Lowest index wins, inner loop sits at index 0
  always_comb
  begin
    logic found;
    found          = 1'b0;
    jump_o         = 1'b0;
    jump_addr_o    = '0;
    hwlp_dec_cnt_o = '0;
    for (int k = 0; k < N_LOOPS; k++)
    begin
      if (hit[k] && !found)
      begin
        found             = 1'b1;
        hwlp_dec_cnt_o[k] = 1'b1;
        // Last pass falls through to the next address
        jump_o            = again[k];
        jump_addr_o       = hwlp_start_addr_i[k];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/hwlp_pc_gen.sv
// Address generator: current address, run flag, consumer credit counter
`timescale 1ns/1ns
`default_nettype none

module hwlp_pc_gen #(
  parameter int CREDITS = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  // Run control from the command stage
  input  logic                run_start_i,
  input  hwlp_cfg_pkg::addr_t run_addr_i,
  input  hwlp_cfg_pkg::addr_t stop_addr_i,
  // Advice from the loop controller
  input  logic                jump_i,
  input  hwlp_cfg_pkg::addr_t jump_addr_i,
  // Credit return from the consumer
  input  logic                pc_credit_i,
  // To the loop controller and register file
  output hwlp_cfg_pkg::addr_t pc_o,
  output logic                issue_o,
  // Address stream to the consumer
  output logic                pc_valid_o,
  output hwlp_cfg_pkg::addr_t pc_addr_o,
  output logic                busy_o
);

  localparam int CW = $clog2(CREDITS + 1);

  logic                run_q;
  hwlp_cfg_pkg::addr_t pc_q;
  logic [CW-1:0]       credit_q;
  logic [CW-1:0]       credit_d;
  logic                issue;
  logic                last;

  // Issue whenever running and the consumer has room
  assign issue = run_q && (credit_q != '0);
  // Stop address reached, this one ends the run
  assign last  = (pc_q == stop_addr_i);

  assign pc_valid_o = issue;
  assign pc_addr_o  = pc_q;
  assign pc_o       = pc_q;
  assign busy_o     = run_q;
  // No loop evaluation on the stop address
  assign issue_o    = issue && !last;

  ////////////////////////////////////////////////////////////
  // Run flag and current address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      run_q <= 1'b0;
      pc_q  <= '0;
    end
    else if (run_start_i)
    begin
      run_q <= 1'b1;
      pc_q  <= run_addr_i;
    end
    else if (issue)
    begin
      if (last)
      begin
        run_q <= 1'b0;
      end
      else if (jump_i)
      begin
        pc_q <= jump_addr_i;
      end
      else
      begin
        pc_q <= pc_q + hwlp_cfg_pkg::addr_t'(hwlp_cfg_pkg::INSTR_STEP);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////

  // Spend on issue, refill on return; both may hit in one cycle
  always_comb
  begin
    credit_d = credit_q;
    if (pc_credit_i)
    begin
      credit_d = credit_d + 1'b1;
    end
    if (issue)
    begin
      credit_d = credit_d - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credit_q <= CW'(CREDITS);
    end
    else
    begin
      credit_q <= credit_d;
    end
  end

  // Consumer returns no more than it received
  a_credit_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
      (pc_credit_i && !pc_valid_o) |-> (credit_q < CW'(CREDITS))
  );

endmodule

`default_nettype wire

// File: src/hwlp_seq_top.sv
// Hardware-loop sequencer top: command stage, loop registers, controller, address generator
`timescale 1ns/1ns
`default_nettype none

module hwlp_seq_top #(
  parameter int N_LOOPS = 2,
  parameter int CREDITS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // Host command port
  input  logic                                   cmd_valid_i,
  input  hwlp_cmd_pkg::cmd_op_e                  cmd_op_i,
  input  logic [((N_LOOPS > 1) ? $clog2(N_LOOPS) : 1)-1:0] cmd_regid_i,
  input  hwlp_cfg_pkg::addr_t                    cmd_data_i,
  output logic                                   busy_o,
  // Consumer port
  output logic                                   pc_valid_o,
  output hwlp_cfg_pkg::addr_t                    pc_addr_o,
  input  logic                                   pc_credit_i
);

  localparam int IDX_W = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1;

  // Command stage to loop registers
  logic [hwlp_cmd_pkg::WE_W-1:0]     we;
  logic [IDX_W-1:0]                  regid;
  hwlp_cfg_pkg::addr_t               start_data;
  hwlp_cfg_pkg::addr_t               end_data;
  hwlp_cfg_pkg::cnt_t                cnt_data;
  // Command stage to address generator
  logic                              run_start;
  hwlp_cfg_pkg::addr_t               run_addr;
  hwlp_cfg_pkg::addr_t               stop_addr;
  // Loop registers to controller
  hwlp_cfg_pkg::addr_t [N_LOOPS-1:0] start_addr;
  hwlp_cfg_pkg::addr_t [N_LOOPS-1:0] end_addr;
  hwlp_cfg_pkg::cnt_t  [N_LOOPS-1:0] counter;
  // Controller and address generator loop
  hwlp_cfg_pkg::addr_t               pc;
  logic                              issue;
  logic                              jump;
  hwlp_cfg_pkg::addr_t               jump_addr;
  logic [N_LOOPS-1:0]                dec_cnt;

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////

  hwlp_cmd_decode #(.N_LOOPS(N_LOOPS)) u_cmd_decode (
    .clk (clk), .rst_n (rst_n),
    .cmd_valid_i (cmd_valid_i), .cmd_op_i (cmd_op_i),
    .cmd_regid_i (cmd_regid_i), .cmd_data_i (cmd_data_i),
    .busy_i (busy_o),
    .hwlp_we_o (we), .hwlp_regid_o (regid),
    .hwlp_start_data_o (start_data), .hwlp_end_data_o (end_data),
    .hwlp_cnt_data_o (cnt_data),
    .run_start_o (run_start), .run_addr_o (run_addr), .stop_addr_o (stop_addr)
  );

  hwlp_regs #(.N_LOOPS(N_LOOPS)) u_regs (
    .clk (clk), .rst_n (rst_n),
    .hwlp_start_data_i (start_data), .hwlp_end_data_i (end_data),
    .hwlp_cnt_data_i (cnt_data), .hwlp_we_i (we), .hwlp_regid_i (regid),
    .valid_i (issue), .hwlp_dec_cnt_i (dec_cnt),
    .hwlp_start_addr_o (start_addr), .hwlp_end_addr_o (end_addr),
    .hwlp_counter_o (counter)
  );

  hwlp_ctrl #(.N_LOOPS(N_LOOPS)) u_ctrl (
    .pc_i (pc),
    .hwlp_start_addr_i (start_addr), .hwlp_end_addr_i (end_addr),
    .hwlp_counter_i (counter),
    .jump_o (jump), .jump_addr_o (jump_addr), .hwlp_dec_cnt_o (dec_cnt)
  );

  hwlp_pc_gen #(.CREDITS(CREDITS)) u_pc_gen (
    .clk (clk), .rst_n (rst_n),
    .run_start_i (run_start), .run_addr_i (run_addr), .stop_addr_i (stop_addr),
    .jump_i (jump), .jump_addr_i (jump_addr), .pc_credit_i (pc_credit_i),
    .pc_o (pc), .issue_o (issue),
    .pc_valid_o (pc_valid_o), .pc_addr_o (pc_addr_o), .busy_o (busy_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_hwlp_seq.sv
// Testbench for the hardware-loop sequencer: clock, reset, host commands, consumer, model, checks
`timescale 1ns/1ns
`default_nettype none

module tb_hwlp_seq;

  localparam int N_LOOPS      = 2;
  localparam int CREDITS      = 4;
  localparam int IDX_W        = (N_LOOPS > 1) ? $clog2(N_LOOPS) : 1;
  localparam int CLK_PERIOD   = 100;
  // Worst credit round trip with the longest return delay
  localparam int STALL_MARGIN = 8;
  localparam int RUN_OVERHEAD = 16;
  localparam int CMD_CYCLES   = 2;

  logic                            clk;
  logic                            rst_n;
  logic                            cmd_valid_i;
  hwlp_cmd_pkg::cmd_op_e           cmd_op_i;
  logic [IDX_W-1:0]                cmd_regid_i;
  hwlp_cfg_pkg::addr_t             cmd_data_i;
  logic                            busy_o;
  logic                            pc_valid_o;
  hwlp_cfg_pkg::addr_t             pc_addr_o;
  logic                            pc_credit_i;

  // Shadow of the loop registers as written by the host
  hwlp_cfg_pkg::addr_t             sh_start [N_LOOPS];
  hwlp_cfg_pkg::addr_t             sh_end   [N_LOOPS];
  hwlp_cfg_pkg::cnt_t              sh_cnt   [N_LOOPS];
  hwlp_cfg_pkg::addr_t             sh_stop;

  // Predicted stream and its head, as seen by the checks
  hwlp_cfg_pkg::addr_t             exp_q [$];
  hwlp_cfg_pkg::addr_t             exp_head;
  int                              exp_left;
  // Consumer: cycle numbers at which each credit goes back
  int unsigned                     due_q [$];
  int unsigned                     cycle_cnt;
  int                              max_delay;
  int                              outstanding;
  integer                          seed;
  longint                          budget_ns;
  int                              mismatch_cnt;
  int                              fail_cnt;

  hwlp_seq_top #(.N_LOOPS(N_LOOPS), .CREDITS(CREDITS)) u_dut (
    .clk (clk), .rst_n (rst_n),
    .cmd_valid_i (cmd_valid_i), .cmd_op_i (cmd_op_i),
    .cmd_regid_i (cmd_regid_i), .cmd_data_i (cmd_data_i),
    .busy_o (busy_o),
    .pc_valid_o (pc_valid_o), .pc_addr_o (pc_addr_o), .pc_credit_i (pc_credit_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Consumer and stream bookkeeping
  ////////////////////////////////////////////////////////////

  task automatic refresh_expect();
    exp_left = exp_q.size();
    exp_head = (exp_left != 0) ? exp_q[0] : '0;
  endtask

  // Accept every address, schedule its credit, retire the prediction
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (rst_n)
    begin
      if (pc_valid_o)
      begin
        due_q.push_back(cycle_cnt + ($unsigned($random(seed)) % (max_delay + 1)));
        outstanding++;
        if (exp_q.size() != 0)
        begin
          void'(exp_q.pop_front());
        end
      end
      if (pc_credit_i)
      begin
        outstanding--;
      end
    end
    refresh_expect();
  end

  // At most one credit back per cycle, oldest first
  always @(negedge clk)
  begin
    pc_credit_i = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cycle_cnt)
    begin
      void'(due_q.pop_front());
      pc_credit_i = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Walk the address rule on the shadow registers up to the stop address
  task automatic predict_stream(input hwlp_cfg_pkg::addr_t entry);
    hwlp_cfg_pkg::addr_t a;
    int                  hit;
    a = entry;
    exp_q.delete();
    while (1)
    begin
      exp_q.push_back(a);
      if (a == sh_stop)
      begin
        break;
      end
      if (exp_q.size() > 1024)
      begin
        $display("Model stream never reaches stop address 0x%08h", sh_stop);
        fail_cnt++;
        break;
      end
      hit = -1;
      for (int k = N_LOOPS - 1; k >= 0; k--)
      begin
        if (sh_cnt[k] != 0 && sh_end[k] == a)
        begin
          hit = k;
        end
      end
      if (hit >= 0 && sh_cnt[hit] > 1)
      begin
        sh_cnt[hit] = sh_cnt[hit] - 1;
        a = sh_start[hit];
      end
      else
      begin
        // Last pass or no match, counter of a last pass drops to zero
        if (hit >= 0)
        begin
          sh_cnt[hit] = '0;
        end
        a = a + 4;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_addr_match : assert property (
    @(posedge clk) disable iff (!rst_n) (pc_valid_o && exp_left != 0) |-> (pc_addr_o == exp_head)
  )
  else
  begin
    $display("MISMATCH pc_addr_o: got 0x%08h expected 0x%08h",
             $sampled(pc_addr_o), $sampled(exp_head));
    mismatch_cnt++;
  end

  // Nothing may leave before a run or past the predicted stream
  a_no_stray_addr : assert property (
    @(posedge clk) disable iff (!rst_n) pc_valid_o |-> (exp_left != 0)
  )
  else
  begin
    $display("Address 0x%08h issued while none was expected", $sampled(pc_addr_o));
    fail_cnt++;
  end

  a_outstanding : assert property (
    @(posedge clk) disable iff (!rst_n) outstanding <= CREDITS
  )
  else
  begin
    $display("Too many outstanding addresses: %0d with %0d credits",
             $sampled(outstanding), CREDITS);
    fail_cnt++;
  end

  a_valid_in_run : assert property (
    @(posedge clk) disable iff (!rst_n) pc_valid_o |-> busy_o
  )
  else
  begin
    $display("MISMATCH busy_o: got 0x%0h expected 0x1", $sampled(busy_o));
    mismatch_cnt++;
  end

  // Run ends the cycle after the stop address leaves
  a_busy_after_stop : assert property (
    @(posedge clk) disable iff (!rst_n) (pc_valid_o && exp_left == 1) |=> !busy_o
  )
  else
  begin
    $display("MISMATCH busy_o: got 0x%0h expected 0x0", $sampled(busy_o));
    mismatch_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // Host command tasks
  ////////////////////////////////////////////////////////////

  task automatic send_cmd(input hwlp_cmd_pkg::cmd_op_e op, input int regid,
                          input hwlp_cfg_pkg::addr_t data);
    budget_ns   = budget_ns + CMD_CYCLES * CLK_PERIOD;
    @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_regid_i = IDX_W'(regid);
    cmd_data_i  = data;
    @(negedge clk);
    cmd_valid_i = 1'b0;
  endtask

  task automatic write_loop(input int k, input hwlp_cfg_pkg::addr_t s,
                            input hwlp_cfg_pkg::addr_t e, input hwlp_cfg_pkg::cnt_t c);
    send_cmd(hwlp_cmd_pkg::OP_START, k, s);
    send_cmd(hwlp_cmd_pkg::OP_END, k, e);
    send_cmd(hwlp_cmd_pkg::OP_COUNT, k, c);
    sh_start[k] = s;
    sh_end[k]   = e;
    sh_cnt[k]   = c;
  endtask

  task automatic set_stop(input hwlp_cfg_pkg::addr_t a);
    send_cmd(hwlp_cmd_pkg::OP_STOP, 0, a);
    sh_stop = a;
  endtask

  // Predict, start the run, then wait for busy to rise and fall
  task automatic run_stream(input hwlp_cfg_pkg::addr_t entry);
    int guard;
    int len;
    predict_stream(entry);
    len       = exp_q.size();
    budget_ns = budget_ns + longint'(len + RUN_OVERHEAD) * STALL_MARGIN * CLK_PERIOD;
    refresh_expect();
    send_cmd(hwlp_cmd_pkg::OP_RUN, 0, entry);
    guard = 0;
    while (busy_o !== 1'b1 && guard < RUN_OVERHEAD)
    begin
      @(negedge clk);
      guard++;
    end
    if (busy_o !== 1'b1)
    begin
      $display("busy_o never rose after run command at 0x%08h", entry);
      fail_cnt++;
    end
    guard = 0;
    while (busy_o === 1'b1 && guard < (len + RUN_OVERHEAD) * STALL_MARGIN)
    begin
      @(negedge clk);
      guard++;
    end
    if (busy_o === 1'b1)
    begin
      $display("Run from 0x%08h never ended, busy_o still high", entry);
      fail_cnt++;
    end
    assert (exp_q.size() == 0)
    else
    begin
      $display("Run from 0x%08h ended with %0d addresses not issued", entry, exp_q.size());
      fail_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_op_i     = hwlp_cmd_pkg::OP_START;
    cmd_regid_i  = '0;
    cmd_data_i   = '0;
    pc_credit_i  = 1'b0;
    seed         = 41;
    cycle_cnt    = 0;
    max_delay    = 0;
    outstanding  = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    budget_ns    = 64 * CLK_PERIOD;
    sh_stop      = '0;
    for (int k = 0; k < N_LOOPS; k++)
    begin
      sh_start[k] = '0;
      sh_end[k]   = '0;
      sh_cnt[k]   = '0;
    end
    refresh_expect();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state, then idle with no run
    assert (pc_valid_o == 1'b0 && busy_o == 1'b0)
    else
    begin
      $display("MISMATCH pc_valid_o/busy_o: got 0x%0h/0x%0h expected 0x0/0x0",
               pc_valid_o, busy_o);
      mismatch_cnt++;
    end
    repeat (4) @(negedge clk);

    // Straight line, all counts zero
    set_stop(32'h0000_1020);
    run_stream(32'h0000_1000);

    // Single loop with count 3, 1 and 0
    write_loop(0, 32'h0000_2008, 32'h0000_2010, 3);
    set_stop(32'h0000_2020);
    run_stream(32'h0000_2000);
    write_loop(0, 32'h0000_2008, 32'h0000_2010, 1);
    run_stream(32'h0000_2000);
    write_loop(0, 32'h0000_2008, 32'h0000_2010, 0);
    run_stream(32'h0000_2000);

    // Nested, distinct ends
    write_loop(0, 32'h0000_3008, 32'h0000_3010, 2);
    write_loop(1, 32'h0000_3004, 32'h0000_3014, 3);
    set_stop(32'h0000_3018);
    run_stream(32'h0000_3000);
    // Nested, shared end, index 0 wins first
    write_loop(0, 32'h0000_4008, 32'h0000_4010, 2);
    write_loop(1, 32'h0000_4004, 32'h0000_4010, 2);
    set_stop(32'h0000_4014);
    run_stream(32'h0000_4000);

    // Slow consumer
    max_delay = 7;
    write_loop(0, 32'h0000_5000, 32'h0000_5008, 4);
    write_loop(1, 32'h0000_5000, 32'h0000_500c, 3);
    set_stop(32'h0000_5010);
    run_stream(32'h0000_5000);

    // Reprogram between two runs
    max_delay = 3;
    write_loop(0, 32'h0000_6000, 32'h0000_6004, 5);
    write_loop(1, 32'h0000_6000, 32'h0000_6008, 0);
    set_stop(32'h0000_600c);
    run_stream(32'h0000_6000);
    write_loop(0, 32'h0000_6100, 32'h0000_6108, 2);
    write_loop(1, 32'h0000_60f8, 32'h0000_610c, 2);
    set_stop(32'h0000_6110);
    run_stream(32'h0000_60f0);

    repeat (RUN_OVERHEAD) @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog, budget grows with every command and predicted stream
  always @(posedge clk)
  begin
    if ($time > budget_ns)
    begin
      $display("Watchdog expired at %0t ns, simulation did not complete", $time);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: src.f
src/hwlp_cfg_pkg.sv
src/hwlp_cmd_pkg.sv
src/hwlp_cmd_decode.sv
src/hwlp_regs.sv
src/hwlp_ctrl.sv
src/hwlp_pc_gen.sv
src/hwlp_seq_top.sv
sim/tb_hwlp_seq.sv
